// File: hdl/crom_defines.svh
// Control store microword layout for the microsequencer
//   Microword, address and call stack sizes
//   Field positions within the registered microword
// Bit 0 is the most significant bit, as in the processor prints

`ifndef CROM_DEFINES_SVH
`define CROM_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Sizes
////////////////////////////////////////////////////////////////////////////

// Registered microword from the control ROM
`define CROM_WIDTH 24

// Microcode address, 4K words of control store
`define ADDR_WIDTH 12

// Subroutine nesting available to the microcode
`define STACK_DEPTH 4

////////////////////////////////////////////////////////////////////////////
// Microword fields, big-endian bit numbers
////////////////////////////////////////////////////////////////////////////

// Jump address
`define CROM_J 0:11

// Subroutine call, pushes the current address
`define CROM_CALL 12

// Dispatch enables
`define CROM_DISP_EN_10 13
`define CROM_DISP_EN_20 14
`define CROM_DISP_EN_40 15

// High byte and low nibble dispatch selects
`define CROM_DISP_SELH 16:17
`define CROM_DISP_SEL 18:20

// Skip condition select
`define CROM_SKIP_SEL 21:23

`endif

// File: hdl/ucodePkg.sv
// Microcode field types for the microsequencer
//   dispSelH_t   high byte dispatch select
//   dispSel_t    low nibble dispatch select, both enable tables
//   skipSel_t    skip condition select

package ucodePkg;

   ////////////////////////////////////////////////////////////////////////////
   // Dispatch selects
   ////////////////////////////////////////////////////////////////////////////

   // High byte source, used with EN20
   typedef enum logic [1:0] {
      selhDIAG  = 2'd0,
      selhRET   = 2'd1,
      selhJ     = 2'd2,
      selhAREAD = 2'd3
   } dispSelH_t;

   // Low nibble source under EN10
   typedef enum logic [2:0] {
      selDIAG     = 3'd0,
      selRET      = 3'd1,
      selMULTIPLY = 3'd2,
      selPAGEFAIL = 3'd3,
      selNICOND   = 3'd4,
      selBYTE     = 3'd5,
      selEAMODE   = 3'd6,
      selSCAD     = 3'd7
   } dispSel_t;

   // Same codes, names as decoded under EN40
   localparam dispSel_t selZERO     = dispSel_t'(3'd0);
   localparam dispSel_t selDP18TO21 = dispSel_t'(3'd1);
   localparam dispSel_t selJ        = dispSel_t'(3'd2);
   localparam dispSel_t selAREAD    = dispSel_t'(3'd3);
   localparam dispSel_t selNORM     = dispSel_t'(3'd4);
   localparam dispSel_t selDP32TO35 = dispSel_t'(3'd5);
   localparam dispSel_t selDROMA    = dispSel_t'(3'd6);
   localparam dispSel_t selDROMB    = dispSel_t'(3'd7);

   ////////////////////////////////////////////////////////////////////////////
   // Skip select
   ////////////////////////////////////////////////////////////////////////////

   // Code n picks bit n of the skip condition bus
   typedef enum logic [2:0] {
      skipNONE   = 3'd0,
      skipCRY0   = 3'd1,
      skipADEQ0  = 3'd2,
      skipDPNEG  = 3'd3,
      skipSCNEG  = 3'd4,
      skipINTRPT = 3'd5,
      skipKERNEL = 3'd6,
      skipIOLGL  = 3'd7
   } skipSel_t;

endpackage

// File: hdl/dispatch.sv
// N-way dispatch for the microsequencer
//   High byte from one of four 12-bit sources under EN20
//   Low nibble from the EN10 or EN40 table
// Output only sets address bits, it is ORed onto J downstream

`timescale 1ns/100ps

`include "crom_defines.svh"

module dispatch
   import ucodePkg::*;
(
   input  logic                                 dispEN10,
   input  logic                                 dispEN20,
   input  logic                                 dispEN40,
   input  dispSelH_t                            dispSELH,
   input  dispSel_t                             dispSEL,
   input  logic [0:35]                          dp,
   input  logic [0:`ADDR_WIDTH-1]               dispDIAG,
   input  logic [0:`ADDR_WIDTH-1]               dispRET,
   input  logic [0:`ADDR_WIDTH-1]               dispJ,
   input  logic [0:`ADDR_WIDTH-1]               dispAREAD,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispMUL,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispPF,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispNI,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispBYTE,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispEA,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispSCAD,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispNORM,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispDROMA,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispDROMB,
   output logic [0:`ADDR_WIDTH-1]               dispAddr
);

   ////////////////////////////////////////////////////////////////////////////
   // Dispatch address mux
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      // Nothing enabled, no bits contributed
      dispAddr = '0;

      // High byte select
      if (dispEN20)
      begin
         case (dispSELH)
            selhDIAG:  dispAddr[0:7] = dispDIAG[0:7];
            selhRET:   dispAddr[0:7] = dispRET[0:7];
            selhJ:     dispAddr[0:7] = dispJ[0:7];
            selhAREAD: dispAddr[0:7] = dispAREAD[0:7];
         endcase
      end

      // Low nibble, control and decode sources
      if (dispEN10)
      begin
         case (dispSEL)
            selDIAG:     dispAddr[8:11] = dispDIAG[8:11];
            selRET:      dispAddr[8:11] = dispRET[8:11];
            selMULTIPLY: dispAddr[8:11] = dispMUL;
            selPAGEFAIL: dispAddr[8:11] = dispPF;
            selNICOND:   dispAddr[8:11] = dispNI;
            selBYTE:     dispAddr[8:11] = dispBYTE;
            selEAMODE:   dispAddr[8:11] = dispEA;
            selSCAD:     dispAddr[8:11] = dispSCAD;
         endcase
      end

      // Low nibble, datapath and DROM sources
      // Evaluated last so EN40 overrides EN10
      if (dispEN40)
      begin
         case (dispSEL)
            selZERO:     dispAddr[8:11] = 4'b0000;
            selDP18TO21: dispAddr[8:11] = dp[18:21];
            selJ:        dispAddr[8:11] = dispJ[8:11];
            selAREAD:    dispAddr[8:11] = dispAREAD[8:11];
            selNORM:     dispAddr[8:11] = dispNORM;
            selDP32TO35: dispAddr[8:11] = dp[32:35];
            selDROMA:    dispAddr[8:11] = dispDROMA;
            selDROMB:    dispAddr[8:11] = dispDROMB;
         endcase
      end
   end

endmodule

// File: hdl/skipLogic.sv
// Conditional skip for the microsequencer
//   Picks one of eight skip conditions from the microword select
//   Result feeds the least significant address bit

`timescale 1ns/100ps

module skipLogic
   import ucodePkg::*;
(
   input  skipSel_t    skipSel,
   input  logic [0:7]  skipCond,
   output logic        skipBit
);

   ////////////////////////////////////////////////////////////////////////////
   // Condition select
   ////////////////////////////////////////////////////////////////////////////

   // Selected condition, bit n for code n
   logic condSel;

   // Select code enabled
   logic skipEn;

   // Index the bus directly by the select code
   assign condSel = skipCond[skipSel];

   // Code 0 means no skip, bit 0 of the bus is a don't care
   assign skipEn = (skipSel != skipNONE);

   // Skip can only set address bit 11, never clear it
   assign skipBit = skipEn & condSel;

endmodule

// File: hdl/callStack.sv
// Microcode subroutine return stack
//   Push of the current address on CALL
//   Pop on a RET dispatch, pop before push when both arrive
//   Sticky error flag on overflow or underflow

`timescale 1ns/100ps

`include "crom_defines.svh"

module callStack
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     push,
   input  logic                     pop,
   input  logic [0:`ADDR_WIDTH-1]   pushAddr,
   output logic [0:`ADDR_WIDTH-1]   retAddr,
   output logic                     stackErr
);

   // Pointer counts entries, so it needs one value past the depth
   localparam int ptrWidth = $clog2(`STACK_DEPTH + 1);
   localparam int idxWidth = $clog2(`STACK_DEPTH);
   localparam logic [ptrWidth-1:0] fullLevel = ptrWidth'(`STACK_DEPTH);

   // Return address storage
   logic [0:`ADDR_WIDTH-1] stackMem [0:`STACK_DEPTH-1];

   // Number of valid entries
   logic [ptrWidth-1:0] sp;

   // Depth after the pop half of the cycle
   logic [ptrWidth-1:0] popLevel;
   logic [idxWidth-1:0] topIdx;
   logic [idxWidth-1:0] wrIdx;
   logic                empty;
   logic                full;
   logic                popOk;
   logic                popErr;
   logic                pushOk;
   logic                pushErr;

   ////////////////////////////////////////////////////////////////////////////
   // Pointer arithmetic
   ////////////////////////////////////////////////////////////////////////////

   assign empty = (sp == '0);
   assign full  = (sp == fullLevel);

   // Pop goes first
   assign popOk    = pop & ~empty;
   assign popErr   = pop & empty;
   assign popLevel = popOk ? sp - ptrWidth'(1) : sp;

   // Push checks room left after the pop
   assign pushOk  = push & (popLevel != fullLevel);
   assign pushErr = push & (popLevel == fullLevel);

   assign topIdx = idxWidth'(sp - ptrWidth'(1));
   assign wrIdx  = idxWidth'(popLevel);

   // Top entry, zero when nothing is stacked
   assign retAddr = empty ? '0 : stackMem[topIdx];

   ////////////////////////////////////////////////////////////////////////////
   // State
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         sp       <= '0;
         stackErr <= 1'b0;
      end
      else
      begin
         sp <= pushOk ? popLevel + ptrWidth'(1) : popLevel;
         // Held until the next reset
         if (popErr | pushErr)
            stackErr <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (pushOk & ~rst)
         stackMem[wrIdx] <= pushAddr;
   end

   // Push with no pop on a full stack is dropped
   overflowChk: assert property (@(posedge clk) disable iff (rst) !(push && !pop && full))
      else $warning("call stack overflow, push of %h dropped", pushAddr);

   // Return with nothing stacked
   underflowChk: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
      else $warning("call stack underflow");

endmodule

// File: hdl/nextAddr.sv
// Next microcode address
//   OR of jump address, dispatch bits and skip bit
//   Current address register read by the control ROM

`timescale 1ns/100ps

`include "crom_defines.svh"

module nextAddr
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic [0:`ADDR_WIDTH-1]   jAddr,
   input  logic [0:`ADDR_WIDTH-1]   dispAddr,
   input  logic                     skipBit,
   output logic [0:`ADDR_WIDTH-1]   currAddr
);

   // Skip bit widened onto address bit 11
   logic [0:`ADDR_WIDTH-1] skipAddr;

   // Combined next address
   logic [0:`ADDR_WIDTH-1] nextAddrVal;

   ////////////////////////////////////////////////////////////////////////////
   // Address combine
   ////////////////////////////////////////////////////////////////////////////

   assign skipAddr = {{(`ADDR_WIDTH-1){1'b0}}, skipBit};

   // Dispatch and skip only set bits of J
   assign nextAddrVal = jAddr | dispAddr | skipAddr;

   ////////////////////////////////////////////////////////////////////////////
   // Address register
   ////////////////////////////////////////////////////////////////////////////

   // Loaded every cycle with no stall
   always_ff @(posedge clk)
   begin
      if (rst)
         currAddr <= '0;
      else
         currAddr <= nextAddrVal;
   end

endmodule

// File: hdl/microseq.sv
// Microsequencer top level
//   Microword field slicing
//   Return pop decode from the RET high byte dispatch
//   Dispatch, skip, call stack and address register blocks

`timescale 1ns/100ps

`include "crom_defines.svh"

module microseq
   import ucodePkg::*;
(
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic [0:`CROM_WIDTH-1]               crom,
   input  logic [0:35]                          dp,
   input  logic [0:`ADDR_WIDTH-1]               dispDIAG,
   input  logic [0:`ADDR_WIDTH-1]               dispJ,
   input  logic [0:`ADDR_WIDTH-1]               dispAREAD,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispMUL,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispPF,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispNI,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispBYTE,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispEA,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispSCAD,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispNORM,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispDROMA,
   input  logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1]   dispDROMB,
   input  logic [0:7]                           skipCond,
   output logic [0:`ADDR_WIDTH-1]               currAddr,
   output logic                                 stackErr
);

   ////////////////////////////////////////////////////////////////////////////
   // Microword fields
   ////////////////////////////////////////////////////////////////////////////

   logic [0:`ADDR_WIDTH-1] jAddr;
   logic                   call;
   logic                   dispEN10;
   logic                   dispEN20;
   logic                   dispEN40;
   dispSelH_t              dispSELH;
   dispSel_t               dispSEL;
   skipSel_t               skipSel;

   // Block outputs
   logic [0:`ADDR_WIDTH-1] dispAddr;
   logic [0:`ADDR_WIDTH-1] retAddr;
   logic                   skipBit;
   logic                   retPop;

   assign jAddr    = crom[`CROM_J];
   assign call     = crom[`CROM_CALL];
   assign dispEN10 = crom[`CROM_DISP_EN_10];
   assign dispEN20 = crom[`CROM_DISP_EN_20];
   assign dispEN40 = crom[`CROM_DISP_EN_40];
   assign dispSELH = dispSelH_t'(crom[`CROM_DISP_SELH]);
   assign dispSEL  = dispSel_t'(crom[`CROM_DISP_SEL]);
   assign skipSel  = skipSel_t'(crom[`CROM_SKIP_SEL]);

   // Return is the RET high byte dispatch
   assign retPop = dispEN20 & (dispSELH == selhRET);

   ////////////////////////////////////////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////////////////////////////////////////

   dispatch i_dispatch (
      .dispEN10  (dispEN10),
      .dispEN20  (dispEN20),
      .dispEN40  (dispEN40),
      .dispSELH  (dispSELH),
      .dispSEL   (dispSEL),
      .dp        (dp),
      .dispDIAG  (dispDIAG),
      .dispRET   (retAddr),
      .dispJ     (dispJ),
      .dispAREAD (dispAREAD),
      .dispMUL   (dispMUL),
      .dispPF    (dispPF),
      .dispNI    (dispNI),
      .dispBYTE  (dispBYTE),
      .dispEA    (dispEA),
      .dispSCAD  (dispSCAD),
      .dispNORM  (dispNORM),
      .dispDROMA (dispDROMA),
      .dispDROMB (dispDROMB),
      .dispAddr  (dispAddr)
   );

   skipLogic i_skipLogic (
      .skipSel  (skipSel),
      .skipCond (skipCond),
      .skipBit  (skipBit)
   );

   // Calling microword address goes on the stack
   callStack i_callStack (
      .clk      (clk),
      .rst      (rst),
      .push     (call),
      .pop      (retPop),
      .pushAddr (currAddr),
      .retAddr  (retAddr),
      .stackErr (stackErr)
   );

   nextAddr i_nextAddr (
      .clk      (clk),
      .rst      (rst),
      .jAddr    (jAddr),
      .dispAddr (dispAddr),
      .skipBit  (skipBit),
      .currAddr (currAddr)
   );

   // A live microword always carries a defined skip select
   skipSelKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(skipSel))
      else $error("skip select unknown at address %h", currAddr);

endmodule

// File: tb/microseq_tb.sv
// Testbench for the microsequencer
//   Reads one microword step per line from the cases file
//   Drives crom, dp and skip conditions shortly after each rising edge
//   Checks next address and stack error flag after the following edge
//   Watchdog sized from the number of steps

`timescale 1ns/100ps

`include "crom_defines.svh"

module microseq_tb;

   ////////////////////////////////////////////////////////////////////////////
   // Clock, reset and DUT signals
   ////////////////////////////////////////////////////////////////////////////

   localparam int clkPeriod      = 10;
   localparam int resetCycles    = 8;
   localparam int watchdogMargin = 100;

   logic                               clk;
   logic                               rst;
   logic [0:`CROM_WIDTH-1]             crom;
   logic [0:35]                        dp;
   logic [0:`ADDR_WIDTH-1]             dispDIAG;
   logic [0:`ADDR_WIDTH-1]             dispJ;
   logic [0:`ADDR_WIDTH-1]             dispAREAD;
   logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1] dispMUL;
   logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1] dispPF;
   logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1] dispNI;
   logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1] dispBYTE;
   logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1] dispEA;
   logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1] dispSCAD;
   logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1] dispNORM;
   logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1] dispDROMA;
   logic [`ADDR_WIDTH-4:`ADDR_WIDTH-1] dispDROMB;
   logic [0:7]                         skipCond;
   logic [0:`ADDR_WIDTH-1]             currAddr;
   logic                               stackErr;

   // Steps from the cases file
   logic [0:`CROM_WIDTH-1] cromQ [$];
   logic [0:35]            dpQ [$];
   logic [0:7]             condQ [$];
   logic [0:`ADDR_WIDTH-1] addrQ [$];
   logic                   errQ [$];
   bit                     casesLoaded;
   int                     step;
   int                     limitNs;

   microseq i_microseq (
      .clk       (clk),
      .rst       (rst),
      .crom      (crom),
      .dp        (dp),
      .dispDIAG  (dispDIAG),
      .dispJ     (dispJ),
      .dispAREAD (dispAREAD),
      .dispMUL   (dispMUL),
      .dispPF    (dispPF),
      .dispNI    (dispNI),
      .dispBYTE  (dispBYTE),
      .dispEA    (dispEA),
      .dispSCAD  (dispSCAD),
      .dispNORM  (dispNORM),
      .dispDROMA (dispDROMA),
      .dispDROMB (dispDROMB),
      .skipCond  (skipCond),
      .currAddr  (currAddr),
      .stackErr  (stackErr)
   );

   always #(clkPeriod / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // Report, then stop the whole run
   task automatic abortRun(input string reason);
   begin
      $display("%s", reason);
      $display("tests failed");
      $fatal(1, "run stopped at first failure");
   end
   endtask

   // Lines starting with // are comments, blank lines skipped
   task automatic readCases;
      int                     fd;
      int                     n;
      string                  line;
      logic [0:`CROM_WIDTH-1] c;
      logic [0:35]            d;
      logic [0:7]             s;
      logic [0:`ADDR_WIDTH-1] a;
      logic [3:0]             e;
   begin
      fd = $fopen("tb/microseq_cases.txt", "r");
      if (fd == 0)
         abortRun("cannot open the cases file tb/microseq_cases.txt");
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line.substr(0, 1) != "//")
         begin
            n = $sscanf(line, "%h %h %h %h %h", c, d, s, a, e);
            if (n != 5)
               abortRun({"cases file line does not hold five fields: ", line});
            cromQ.push_back(c);
            dpQ.push_back(d);
            condQ.push_back(s);
            addrQ.push_back(a);
            errQ.push_back(e[0]);
         end
      end
      $fclose(fd);
   end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus and checks
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      clk      = 1'b0;
      rst      = 1'b1;
      crom     = '0;
      dp       = '0;
      skipCond = '0;

      // Fixed dispatch sources, the expected addresses assume these
      dispDIAG  = 12'h3c5;
      dispJ     = 12'h6a9;
      dispAREAD = 12'he17;
      dispMUL   = 4'h3;
      dispPF    = 4'h5;
      dispNI    = 4'h6;
      dispBYTE  = 4'h9;
      dispEA    = 4'ha;
      dispSCAD  = 4'hc;
      dispNORM  = 4'hd;
      dispDROMA = 4'he;
      dispDROMB = 4'hb;

      readCases();
      casesLoaded = 1'b1;

      repeat (resetCycles) @(posedge clk);
      #1;
      rst = 1'b0;

      // Reset state
      assert (currAddr === '0 && stackErr === 1'b0)
      else
         abortRun($sformatf("ERROR %0t after reset: address %h stackErr %b, expected 000 and 0",
            $time, currAddr, stackErr));

      // One microword per cycle, result visible after the next edge
      for (step = 0; step < cromQ.size(); step++)
      begin
         crom     = cromQ[step];
         dp       = dpQ[step];
         skipCond = condQ[step];
         @(posedge clk);
         #1;
         assert (currAddr === addrQ[step])
         else
            abortRun($sformatf("ERROR %0t step %0d: expected address %h, got %h",
               $time, step, addrQ[step], currAddr));
         assert (stackErr === errQ[step])
         else
            abortRun($sformatf("ERROR %0t step %0d: expected stackErr %b, got %b",
               $time, step, errQ[step], stackErr));
      end

      $display("all tests passed");
      $finish;
   end

   // Watchdog, reset plus one cycle per step plus a margin
   initial
   begin
      wait (casesLoaded);
      limitNs = (resetCycles + cromQ.size()) * clkPeriod + watchdogMargin;
      #(limitNs);
      abortRun($sformatf("watchdog timeout, run still going after %0d ns", limitNs));
   end

endmodule

// File: microseq.f
+incdir+hdl
hdl/ucodePkg.sv
hdl/dispatch.sv
hdl/skipLogic.sv
hdl/callStack.sv
hdl/nextAddr.sv
hdl/microseq.sv
tb/microseq_tb.sv

// File: Makefile
# Microsequencer simulation with Verilator
#   make        build and run the testbench
#   make lint   lint the RTL top level
#   make clean  remove build output

LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/100ps -f microseq.f \
		--top-module microseq_tb -o Vmicroseq_tb
	-./obj_dir/Vmicroseq_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "FAIL: no pass line in $(LOG)"; exit 1; fi
	@echo "PASS"

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f microseq.f --top-module microseq

clean:
	rm -rf obj_dir $(LOG)

// File: tb/microseq_cases.txt
// crom  dp  skipCond  next address  stackErr, all hex
// One line per clock, the address is checked after the edge that loads it
// Plain jump, skip NONE ignores the conditions
123000 000000000 00 123 0
456000 000000000 ff 456 0
// EN20 high byte DIAG, J, AREAD
001200 000000000 00 3c1 0
00f280 000000000 00 6af 0
1002c0 000000000 00 f10 0
// EN10 low nibble, RET with an empty stack gives zero
200400 000000000 00 205 0
210408 000000000 00 210 0
220410 000000000 00 223 0
230418 000000000 00 235 0
240420 000000000 00 246 0
250428 000000000 00 259 0
260430 000000000 00 26a 0
270438 000000000 00 27c 0
// EN40 low nibble, then EN10 and EN40 together
30f100 000000000 00 30f 0
310108 f0001c002 00 317 0
320128 f0001c002 00 322 0
330110 000000000 00 339 0
340118 000000000 00 347 0
350120 000000000 00 35d 0
360130 000000000 00 36e 0
370138 000000000 00 37b 0
380510 000000000 00 389 0
// Skip selects 1 to 7 on address bit 11
400001 000000000 40 401 0
402001 000000000 bf 402 0
410002 000000000 20 411 0
420003 000000000 10 421 0
430004 000000000 f7 430 0
440005 000000000 04 441 0
450006 000000000 02 451 0
460007 000000000 01 461 0
470007 000000000 fe 470 0
481003 000000000 00 481 0
// Nested calls from 481 and 600, then two returns
500800 000000000 00 500 0
600000 000000000 00 600 0
700800 000000000 00 700 0
001648 000000000 00 601 0
002648 000000000 00 483 0
// Return with an empty stack, error stays set
010240 000000000 00 010 1
020000 000000000 00 020 1
030000 000000000 00 030 1
